/* hw/ctrl_pkg.sv */
// control command front end
// shared opcodes and sizes
`default_nettype none

package ctrl_pkg;

    // opcode bytes, ascii "W" and "K".
    localparam logic [7:0] op_write = 8'h57;
    localparam logic [7:0] op_kick  = 8'h4b;

    // watchdog signature, sent msb first.
    localparam int wdt_sig_bits  = 32;
    localparam int wdt_sig_bytes = wdt_sig_bits / 8;
    localparam logic [wdt_sig_bits-1:0] wdt_sig_pattern = 32'hd06f00d5;

    // countdown reload, short for simulation.
    localparam int wdt_ticks      = 200;
    localparam int wdt_count_bits = $clog2(wdt_ticks + 1);

    // configuration register bank.
    localparam int reg_count     = 4;
    localparam int reg_addr_bits = 2;

    // arm bit inside register 0.
    localparam int wdt_arm_bit = 0;

endpackage

`default_nettype wire

/* hw/control_cmd_dispatch.sv */
// command dispatcher
// opcode decode and byte routing
`default_nettype none

module control_cmd_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       wdt_done,
    input  logic       wr_done,
    output logic [7:0] cmd_data,
    output logic       wdt_enable,
    output logic       wr_enable,
    output logic       bad_cmd
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_kick,
        st_write
    } dispatch_state_t;

    dispatch_state_t state;

    // payload goes straight through to both handlers.
    assign cmd_data = rx_data;

    // bytes seen during a done cycle are dropped.
    assign wdt_enable = rx_valid && (state == st_kick) && !wdt_done;
    assign wr_enable  = rx_valid && (state == st_write) && !wr_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            bad_cmd <= 1'b0;
        end else begin
            bad_cmd <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_valid) begin
                        case (rx_data)
                            op_kick:  state <= st_kick;
                            op_write: state <= st_write;
                            default:  bad_cmd <= 1'b1;
                        endcase
                    end
                end
                st_kick: begin
                    if (wdt_done) begin
                        state <= st_idle;
                    end
                end
                st_write: begin
                    if (wr_done) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/control_cmd_watchdog.sv */
// watchdog handler
// signature capture and countdown
`default_nettype none

module control_cmd_watchdog (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] cmd_data,
    input  logic       enable,
    input  logic       arm,
    output logic       sys_reset,
    output logic       done
);
    import ctrl_pkg::*;

    typedef logic [$clog2(wdt_sig_bytes)-1:0] byte_idx_t;
    typedef logic [wdt_count_bits-1:0] count_t;

    logic [wdt_sig_bits-1:0] cache;
    logic [wdt_sig_bits-1:0] next_cache;
    byte_idx_t               byte_cnt;
    logic                    last_byte;
    logic                    sig_match;
    count_t                  count;

    assign next_cache = {cache[wdt_sig_bits-9:0], cmd_data};
    assign last_byte  = enable && (byte_cnt == byte_idx_t'(wdt_sig_bytes - 1));
    assign sig_match  = last_byte && (next_cache == wdt_sig_pattern);

    // signature collector.
    always_ff @(posedge clk) begin
        if (reset) begin
            cache    <= '0;
            byte_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= last_byte;
            if (done) begin
                cache <= '0;
            end else if (enable) begin
                cache <= next_cache;
            end
            if (last_byte) begin
                byte_cnt <= '0;
            end else if (enable) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // countdown, held at reload while disarmed.
    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= count_t'(wdt_ticks);
            sys_reset <= 1'b0;
        end else begin
            sys_reset <= (count == '0);
            if (!arm || sig_match || count == '0) begin
                count <= count_t'(wdt_ticks);
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/control_cmd_reg_write.sv */
// register write handler
// address/data collector and config bank
`default_nettype none

module control_cmd_reg_write (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [7:0]                          cmd_data,
    input  logic                                enable,
    output logic [ctrl_pkg::reg_count-1:0][7:0] cfg_regs,
    output logic                                done
);
    import ctrl_pkg::*;

    typedef enum logic {
        st_addr,
        st_data
    } write_state_t;

    write_state_t state;
    logic [7:0]   addr;
    logic         addr_ok;

    // full byte compare, anything past the bank is ignored.
    assign addr_ok = (addr < 8'(reg_count));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_addr;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (enable) begin
                case (state)
                    st_addr: begin
                        state <= st_data;
                    end
                    st_data: begin
                        state <= st_addr;
                        done  <= 1'b1;
                    end
                    default: begin
                        state <= st_addr;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && state == st_addr) begin
            addr <= cmd_data;
        end
    end

    // register bank, cleared so the watchdog starts disarmed.
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_regs <= '0;
        end else if (enable && state == st_data && addr_ok) begin
            cfg_regs[addr[reg_addr_bits-1:0]] <= cmd_data;
        end
    end

endmodule

`default_nettype wire

/* hw/control_top.sv */
// control command front end
// dispatcher with write and watchdog handlers
`default_nettype none

module control_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [7:0]                          rx_data,
    input  logic                                rx_valid,
    output logic [ctrl_pkg::reg_count-1:0][7:0] cfg_regs,
    output logic                                wdt_reset,
    output logic                                bad_cmd
);
    import ctrl_pkg::*;

    logic [7:0] cmd_data;
    logic       wdt_enable;
    logic       wr_enable;
    logic       wdt_done;
    logic       wr_done;

    control_cmd_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .wdt_done   (wdt_done),
        .wr_done    (wr_done),
        .cmd_data   (cmd_data),
        .wdt_enable (wdt_enable),
        .wr_enable  (wr_enable),
        .bad_cmd    (bad_cmd)
    );

    // arm comes from register 0.
    control_cmd_watchdog u_watchdog (
        .clk       (clk),
        .reset     (reset),
        .cmd_data  (cmd_data),
        .enable    (wdt_enable),
        .arm       (cfg_regs[0][wdt_arm_bit]),
        .sys_reset (wdt_reset),
        .done      (wdt_done)
    );

    control_cmd_reg_write u_reg_write (
        .clk      (clk),
        .reset    (reset),
        .cmd_data (cmd_data),
        .enable   (wr_enable),
        .cfg_regs (cfg_regs),
        .done     (wr_done)
    );

endmodule

`default_nettype wire

/* tests/control_props.sv */
// dispatcher and watchdog properties
`default_nettype none

module control_props (
    input logic clk,
    input logic reset,
    input logic wr_enable,
    input logic wdt_enable,
    input logic cmd_active,
    input logic bad_cmd,
    input logic pulse
);
    timeunit 1ns;
    timeprecision 1ps;

    // only one handler sees a byte.
    enables_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(wr_enable && wdt_enable))
        else $error("wr_enable and wdt_enable high in the same cycle");

    // opcodes are only decoded from idle.
    no_bad_cmd_when_active: assert property (@(posedge clk) disable iff (reset)
        cmd_active |=> !bad_cmd)
        else $error("bad_cmd raised right after an active command cycle");

    single_cycle_pulse: assert property (@(posedge clk) disable iff (reset)
        pulse |=> !pulse)
        else $error("one-cycle pulse output held high for two cycles");

endmodule

// bad_cmd is the dispatcher's own one-cycle pulse.
bind control_cmd_dispatch control_props u_props (
    .clk        (clk),
    .reset      (reset),
    .wr_enable  (wr_enable),
    .wdt_enable (wdt_enable),
    .cmd_active (state != st_idle),
    .bad_cmd    (bad_cmd),
    .pulse      (bad_cmd)
);

// a forwarded byte means a command is active.
bind control_top control_props u_props (
    .clk        (clk),
    .reset      (reset),
    .wr_enable  (wr_enable),
    .wdt_enable (wdt_enable),
    .cmd_active (wr_enable || wdt_enable),
    .bad_cmd    (bad_cmd),
    .pulse      (wdt_reset)
);

`default_nettype wire

/* tests/control_tb.sv */
// control front end testbench
`default_nettype none

module control_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ctrl_pkg::*;

    localparam int drive_delay = 2;
    localparam int kick_period = 100;
    localparam int kick_cycles = (wdt_sig_bytes + 1) * 4;

    logic                      clk;
    logic                      reset;
    logic [7:0]                rx_data;
    logic                      rx_valid;
    logic [reg_count-1:0][7:0] cfg_regs;
    logic                      wdt_reset;
    logic                      bad_cmd;

    logic [31:0] rng_state;
    logic [7:0]  model [reg_count];
    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          cycle = 0;
    int          wdt_pulses = 0;
    int          last_pulse_cycle = 0;
    int          bad_pulses = 0;

    control_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .cfg_regs  (cfg_regs),
        .wdt_reset (wdt_reset),
        .bad_cmd   (bad_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // pulse counters, sampled mid-cycle.
    always @(negedge clk) begin
        if (!reset && wdt_reset) begin
            wdt_pulses       <= wdt_pulses + 1;
            last_pulse_cycle <= cycle;
        end
        if (!reset && bad_cmd) begin
            bad_pulses <= bad_pulses + 1;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        rx_data  = value;
        rx_valid = 1'b1;
        idle_cycles(1);
        rx_valid = 1'b0;
        idle_cycles(3);
    endtask

    task automatic send_write(input logic [7:0] addr, input logic [7:0] value);
        send_byte(op_write);
        send_byte(addr);
        send_byte(value);
    endtask

    task automatic send_kick(input logic [wdt_sig_bits-1:0] sig);
        send_byte(op_kick);
        for (int i = wdt_sig_bytes - 1; i >= 0; i--) begin
            send_byte(sig[8*i +: 8]);
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERROR %s: %s expected 0x%0h, got 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < reg_count; i++) begin
            check_value($sformatf("cfg_regs[%0d]", i), int'(model[i]), int'(cfg_regs[i]));
        end
    endtask

    task automatic wait_for_pulse(input int limit, output bit seen, output int at_cycle);
        int waited;
        waited   = 0;
        seen     = 1'b0;
        at_cycle = -1;
        while (!seen && waited <= limit) begin
            if (wdt_reset) begin
                seen     = 1'b1;
                at_cycle = cycle;
            end else begin
                idle_cycles(1);
                waited++;
            end
        end
        assert (seen) else begin
            $display("%s: timed out after %0d cycles waiting for wdt_reset", test_name, limit);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        check_regs();
        // watchdog is disarmed, so nothing may pulse.
        idle_cycles(wdt_ticks + 20);
        check_value("wdt_reset pulses", 0, wdt_pulses);
        check_value("bad_cmd pulses", 0, bad_pulses);
        end_test();
    endtask

    task automatic test_reg_writes();
        logic [31:0] rnd;
        logic [7:0]  addr;
        begin_test("reg_writes");
        for (int i = 1; i < reg_count; i++) begin
            rnd = next_random();
            send_write(8'(i), rnd[7:0]);
            model[i] = rnd[7:0];
            check_regs();
        end
        // address byte reaches past the bank.
        if (reg_count < 256) begin
            rnd  = next_random();
            addr = 8'(reg_count + int'(rnd[1:0]));
            send_write(addr, rnd[15:8]);
            check_regs();
        end
        rnd = next_random();
        send_write(8'(reg_count - 1), rnd[7:0]);
        model[reg_count-1] = rnd[7:0];
        check_regs();
        check_value("bad_cmd pulses", 0, bad_pulses);
        end_test();
    endtask

    task automatic test_expiry();
        bit seen;
        int first_at;
        int second_at;
        begin_test("expiry");
        model[0] = model[0] | (8'h01 << wdt_arm_bit);
        send_write(8'd0, model[0]);
        check_regs();
        // three cycles already spent after the data byte.
        wait_for_pulse(wdt_ticks + 27, seen, first_at);
        if (seen) begin
            idle_cycles(1);
            wait_for_pulse(wdt_ticks + 10, seen, second_at);
            if (seen) begin
                check_value("pulse spacing", wdt_ticks + 1, second_at - first_at);
            end
        end
        idle_cycles(1);
        end_test();
    endtask

    task automatic test_refresh();
        int start_pulses;
        begin_test("refresh");
        start_pulses = wdt_pulses;
        repeat (1000 / kick_period) begin
            send_kick(wdt_sig_pattern);
            idle_cycles(kick_period - kick_cycles);
        end
        check_value("wdt_reset pulses", start_pulses, wdt_pulses);
        end_test();
    endtask

    task automatic test_bad_signature();
        logic [31:0]             rnd;
        logic [wdt_sig_bits-1:0] sig;
        int                      idx;
        int                      start_cycle;
        int                      start_pulses;
        begin_test("bad_signature");
        start_cycle  = cycle;
        start_pulses = wdt_pulses;
        while (wdt_pulses == start_pulses && cycle - start_cycle < wdt_ticks + 30) begin
            rnd = next_random();
            idx = int'(rnd[7:0]) % wdt_sig_bytes;
            sig = wdt_sig_pattern ^ (wdt_sig_bits'(rnd[15:8] | 8'h01) << (8 * idx));
            send_kick(sig);
        end
        idle_cycles(1);
        assert (wdt_pulses > start_pulses) else begin
            $display("%s: wdt_reset never pulsed while kicks were corrupted", test_name);
            test_errors++;
        end
        if (wdt_pulses > start_pulses) begin
            assert (last_pulse_cycle - start_cycle <= wdt_ticks + 30) else begin
                $display("%s: wdt_reset pulsed too late, %0d cycles after start",
                         test_name, last_pulse_cycle - start_cycle);
                test_errors++;
            end
        end
        end_test();
    endtask

    task automatic test_unknown_opcode();
        logic [31:0] rnd;
        logic [7:0]  opcode;
        int          start_bad;
        int          start_pulses;
        begin_test("unknown_opcode");
        rnd    = next_random();
        opcode = rnd[7:0];
        while (opcode == op_write || opcode == op_kick) begin
            opcode = opcode + 8'd1;
        end
        start_bad = bad_pulses;
        send_byte(opcode);
        check_value("bad_cmd pulses", start_bad + 1, bad_pulses);
        rnd = next_random();
        send_write(8'd2, rnd[7:0]);
        model[2] = rnd[7:0];
        check_regs();
        // disarm, the countdown then holds at reload.
        model[0] = model[0] & ~(8'h01 << wdt_arm_bit);
        send_write(8'd0, model[0]);
        check_regs();
        start_pulses = wdt_pulses;
        idle_cycles(wdt_ticks + 20);
        check_value("wdt_reset pulses", start_pulses, wdt_pulses);
        check_value("bad_cmd pulses", start_bad + 1, bad_pulses);
        end_test();
    endtask

    initial begin
        reset        = 1'b1;
        rx_data      = 8'h00;
        rx_valid     = 1'b0;
        rng_state    = 32'hc8db;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < reg_count; i++) begin
            model[i] = 8'h00;
        end
        idle_cycles(8);
        reset = 1'b0;
        test_reset_state();
        test_reg_writes();
        test_expiry();
        test_refresh();
        test_bad_signature();
        test_unknown_opcode();
        $display("tests: %0d run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/ctrl_pkg.sv
hw/control_cmd_dispatch.sv
hw/control_cmd_watchdog.sv
hw/control_cmd_reg_write.sv
hw/control_top.sv
tests/control_props.sv
tests/control_tb.sv

/* Makefile */
# Verilator build and run for the control command front end

TOP = control_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
		--top-module $(TOP) -f verilog.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
